/* verilog.f */
sorter_pkg.sv
sort_memory.sv
sort_loader.sv
sort_engine.sv
sort_unloader.sv
efi_sorter.sv
efi_sorter_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= efi_sorter_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* efi_sorter_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sorter testbench
// sends signed lists to the sorter unit, sorts a copy of each
// and compares every result beat against that reference
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module efi_sorter_tb import sorter_pkg::*; ();

    localparam int MAX_LEN = 16;

    typedef sort_data_t data_queue_t[$];

    function automatic int list_budget(input int n);
        return 5 * n * n + 40;
    endfunction

    // one term per list sent by the tests below
    localparam int CYCLE_LIMIT = 2 * (list_budget(12) + list_budget(1) + list_budget(8)
        + list_budget(10) + list_budget(10) + list_budget(16) + list_budget(20)
        + list_budget(6));

    logic         clock;
    logic         reset;
    stream_beat_t arg;
    logic         arg_valid;
    logic         arg_ready;
    stream_beat_t res;
    logic         res_valid;
    logic         res_ready;

    logic [31:0]  lfsr_state = 32'd679;
    stream_beat_t exp_q[$];
    int           error_count = 0;
    int           check_count = 0;
    int           test_count = 0;
    int           failed_tests = 0;
    int           errors_at_start;
    int           cycle_count = 0;

    efi_sorter #(
        .MAX_SORT_LENGTH(MAX_LEN)
    ) i_efi_sorter (
        .clock    (clock),
        .reset    (reset),
        .arg      (arg),
        .arg_valid(arg_valid),
        .arg_ready(arg_ready),
        .res      (res),
        .res_valid(res_valid),
        .res_ready(res_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois LFSR, one step for every bit handed out
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic data_queue_t random_list(input int n);
        data_queue_t values;
        for (int i = 0; i < n; i++) begin
            values.push_back(sort_data_t'(random_bits(32)));
        end
        return values;
    endfunction

    // keeps the first MAX_LEN words and insertion-sorts them as signed values
    function automatic data_queue_t reference_sort(input data_queue_t values);
        data_queue_t kept;
        sort_data_t  tmp;
        int          j;
        for (int i = 0; i < values.size() && i < MAX_LEN; i++) begin
            kept.push_back(values[i]);
        end
        for (int i = 1; i < kept.size(); i++) begin
            tmp = kept[i];
            j = i - 1;
            while (j >= 0 && kept[j] > tmp) begin
                kept[j+1] = kept[j];
                j--;
            end
            kept[j+1] = tmp;
        end
        return kept;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, expected);
        end
    endtask

    always @(posedge clock) begin : collect_results
        stream_beat_t expected;
        if (!reset && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("a result beat arrived while no result was expected");
            end else begin
                expected = exp_q.pop_front();
                check_value("res.data", res.data, expected.data);
                check_value("res.dest", 32'(res.dest), 32'(expected.dest));
                check_value("res.last", 32'(res.last), 32'(expected.last));
            end
        end
    end

    // arg_ready only changes after a rising edge, so it is stable at the falling one
    task automatic send_list(input data_queue_t values, input logic [DEST_WIDTH-1:0] base);
        for (int i = 0; i < values.size(); i++) begin
            @(negedge clock);
            arg.data  = values[i];
            arg.dest  = base + DEST_WIDTH'(i);
            arg.last  = (i == values.size() - 1);
            arg_valid = 1'b1;
            while (!arg_ready) begin
                @(negedge clock);
            end
            @(posedge clock);
        end
        @(negedge clock);
        arg_valid = 1'b0;
    endtask

    task automatic run_list(input data_queue_t values, input logic [DEST_WIDTH-1:0] base,
                            input logic toggle_ready);
        data_queue_t  sorted;
        stream_beat_t beat;
        sorted = reference_sort(values);
        for (int i = 0; i < sorted.size(); i++) begin
            beat.data = sorted[i];
            beat.dest = base + DEST_WIDTH'(i);
            beat.last = (i == sorted.size() - 1);
            exp_q.push_back(beat);
        end
        send_list(values, base);
        while (exp_q.size() != 0) begin
            @(negedge clock);
            res_ready = toggle_ready ? 1'(random_bits(1)) : 1'b1;
        end
        res_ready = 1'b1;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count != errors_at_start) begin
            failed_tests++;
        end
        $display("test %0d %-30s %0d errors", test_count, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    initial begin : stimulus
        data_queue_t values;
        reset     = 1'b1;
        arg       = '0;
        arg_valid = 1'b0;
        res_ready = 1'b1;
        errors_at_start = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;

        values = random_list(12);
        // make sure the list mixes signs
        values[0] = -sort_data_t'(random_bits(16));
        values[1] = sort_data_t'(random_bits(16));
        run_list(values, 8'h10, 1'b0);
        end_test("random list of 12");

        run_list(random_list(1), 8'h20, 1'b0);
        values.delete();
        for (int i = 0; i < 8; i++) begin
            values.push_back(sort_data_t'(i * 7 - 20));
        end
        run_list(values, 8'h30, 1'b0);
        values.delete();
        for (int i = 0; i < 10; i++) begin
            values.push_back(sort_data_t'((5 - i / 2) * 3));
        end
        run_list(values, 8'h40, 1'b0);
        end_test("single, sorted, reversed");

        run_list(random_list(10), 8'd250, 1'b0);
        end_test("dest wrap from 250");

        run_list(random_list(16), 8'h60, 1'b1);
        end_test("random result back-pressure");

        run_list(random_list(20), 8'h80, 1'b0);
        run_list(random_list(6), 8'h90, 1'b0);
        end_test("overlong list then normal");

        // a stray beat after the last list would still be caught here
        repeat (20) @(negedge clock);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the sorter stopped responding", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* efi_sorter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// extended function unit sorter
// takes a list of signed words on the argument stream and
// returns it sorted ascending on the result stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module efi_sorter import sorter_pkg::*; #(
    // must stay within the package address range
    parameter int MAX_SORT_LENGTH = 256
) (
    input  logic         clock,
    input  logic         reset,
    input  stream_beat_t arg,
    input  logic         arg_valid,
    output logic         arg_ready,
    output stream_beat_t res,
    output logic         res_valid,
    input  logic         res_ready
);

    logic       load_enable;
    mem_write_t load_wr;
    list_info_t list;
    list_info_t start;
    mem_read_t  unload_rd;
    sort_data_t rd_data;
    logic       unload_done;

    sort_loader #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) i_sort_loader (
        .clock      (clock),
        .reset      (reset),
        .arg        (arg),
        .arg_valid  (arg_valid),
        .arg_ready  (arg_ready),
        .load_enable(load_enable),
        .wr         (load_wr),
        .list       (list)
    );

    sort_engine #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) i_sort_engine (
        .clock      (clock),
        .reset      (reset),
        .load_enable(load_enable),
        .load_wr    (load_wr),
        .list       (list),
        .start      (start),
        .unload_rd  (unload_rd),
        .rd_data    (rd_data),
        .unload_done(unload_done)
    );

    sort_unloader i_sort_unloader (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .rd         (unload_rd),
        .rd_data    (rd_data),
        .res        (res),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .unload_done(unload_done)
    );

endmodule

/* sort_unloader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result unloader
// reads the sorted list in order and streams it out with
// incrementing destination addresses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sort_unloader import sorter_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  list_info_t   start,
    output mem_read_t    rd,
    input  sort_data_t   rd_data,
    output stream_beat_t res,
    output logic         res_valid,
    input  logic         res_ready,
    output logic         unload_done
);

    logic                  active;
    logic                  pending;
    logic [ADDR_WIDTH:0]   rd_idx;
    logic [ADDR_WIDTH:0]   pend_idx;
    logic [ADDR_WIDTH:0]   length;
    logic [DEST_WIDTH-1:0] base_dest;
    logic                  slot_free;
    logic                  issue;
    logic                  last_sent;

    // a read is only issued when the output register will be empty on return
    assign slot_free = !res_valid || res_ready;
    assign issue     = active && !pending && slot_free && (rd_idx < length);
    assign last_sent = res_valid && res_ready && res.last;

    // element zero is fetched in the start cycle itself
    assign rd = '{
        en:   start.valid || issue,
        addr: start.valid ? '0 : rd_idx[ADDR_WIDTH-1:0]
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            active      <= 1'b0;
            pending     <= 1'b0;
            rd_idx      <= '0;
            res_valid   <= 1'b0;
            unload_done <= 1'b0;
        end else begin
            pending     <= rd.en;
            unload_done <= last_sent;
            if (start.valid) begin
                active <= 1'b1;
                rd_idx <= (ADDR_WIDTH+1)'(1);
            end else if (issue) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (last_sent) begin
                active <= 1'b0;
            end
            if (pending) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start.valid) begin
            length    <= start.length;
            base_dest <= start.base_dest;
        end
        if (rd.en) begin
            pend_idx <= start.valid ? '0 : rd_idx;
        end
        if (pending) begin
            res.data <= rd_data;
            // destination wraps around the address space
            res.dest <= base_dest + DEST_WIDTH'(pend_idx);
            res.last <= (pend_idx == length - 1'b1);
        end
    end

    a_res_stable: assert property (@(posedge clock) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

/* sort_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sort engine
// owns the list store, shares its ports between the phases and
// runs odd-even transposition passes until the list settles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sort_engine import sorter_pkg::*; #(
    parameter int MAX_SORT_LENGTH = 256
) (
    input  logic       clock,
    input  logic       reset,
    output logic       load_enable,
    input  mem_write_t load_wr,
    input  list_info_t list,
    output list_info_t start,
    input  mem_read_t  unload_rd,
    output sort_data_t rd_data,
    input  logic       unload_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_LEFT,
        ST_READ_RIGHT,
        ST_COMPARE,
        ST_WRITE,
        ST_ADVANCE
    } sort_state_t;

    sorter_phase_t         phase;
    sort_state_t           state;
    logic [ADDR_WIDTH:0]   pos;
    logic [ADDR_WIDTH:0]   pos_next;
    logic [ADDR_WIDTH:0]   cur_len;
    logic [DEST_WIDTH-1:0] cur_base;
    sort_data_t            left;
    logic                  odd_pass;
    logic                  swapped;
    logic                  prev_clean;
    logic                  start_pulse;
    logic                  swap;
    mem_write_t            sort_wr;
    mem_write_t            mem_wr;
    mem_read_t             sort_rd;
    mem_read_t             mem_rd;

    assign pos_next = pos + 1'b1;
    // rd_data holds the right element during the compare cycle
    assign swap = (state == ST_COMPARE) && (left > rd_data);

    // the port closes in the cycle the finished list is reported
    assign load_enable = (phase == PHASE_LOAD) && !list.valid;

    assign sort_rd = '{
        en:   (state == ST_READ_LEFT) || (state == ST_READ_RIGHT),
        addr: (state == ST_READ_RIGHT) ? pos_next[ADDR_WIDTH-1:0] : pos[ADDR_WIDTH-1:0]
    };

    // a swap writes the right word low during compare and the left word high after it
    assign sort_wr = '{
        en:   swap || (state == ST_WRITE),
        addr: (state == ST_WRITE) ? pos_next[ADDR_WIDTH-1:0] : pos[ADDR_WIDTH-1:0],
        data: (state == ST_WRITE) ? left : rd_data
    };

    assign mem_wr = (phase == PHASE_SORT) ? sort_wr : load_wr;
    assign mem_rd = (phase == PHASE_SORT) ? sort_rd : unload_rd;

    assign start = '{valid: start_pulse, length: cur_len, base_dest: cur_base};

    sort_memory #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) i_sort_memory (
        .clock  (clock),
        .wr     (mem_wr),
        .rd     (mem_rd),
        .rd_data(rd_data)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            // leaving reset through the idle sort state keeps the port shut one cycle
            phase       <= PHASE_SORT;
            state       <= ST_IDLE;
            pos         <= '0;
            odd_pass    <= 1'b0;
            swapped     <= 1'b0;
            prev_clean  <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            case (phase)
                PHASE_LOAD: begin
                    if (list.valid) begin
                        if (list.length == (ADDR_WIDTH+1)'(1)) begin
                            phase       <= PHASE_UNLOAD;
                            start_pulse <= 1'b1;
                        end else begin
                            phase      <= PHASE_SORT;
                            state      <= ST_ADVANCE;
                            pos        <= '0;
                            odd_pass   <= 1'b0;
                            swapped    <= 1'b0;
                            prev_clean <= 1'b0;
                        end
                    end
                end
                PHASE_SORT: begin
                    case (state)
                        ST_IDLE:       phase <= PHASE_LOAD;
                        ST_READ_LEFT:  state <= ST_READ_RIGHT;
                        ST_READ_RIGHT: state <= ST_COMPARE;
                        ST_COMPARE: begin
                            if (swap) begin
                                swapped <= 1'b1;
                                state   <= ST_WRITE;
                            end else begin
                                pos   <= pos + (ADDR_WIDTH+1)'(2);
                                state <= ST_ADVANCE;
                            end
                        end
                        ST_WRITE: begin
                            pos   <= pos + (ADDR_WIDTH+1)'(2);
                            state <= ST_ADVANCE;
                        end
                        ST_ADVANCE: begin
                            if (pos_next < cur_len) begin
                                state <= ST_READ_LEFT;
                            end else if (prev_clean && !swapped) begin
                                // an odd and an even pass both clean means sorted
                                phase       <= PHASE_UNLOAD;
                                state       <= ST_IDLE;
                                start_pulse <= 1'b1;
                            end else begin
                                prev_clean <= !swapped;
                                swapped    <= 1'b0;
                                odd_pass   <= !odd_pass;
                                pos        <= {{ADDR_WIDTH{1'b0}}, !odd_pass};
                            end
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
                PHASE_UNLOAD: begin
                    if (unload_done) begin
                        phase <= PHASE_LOAD;
                    end
                end
                default: phase <= PHASE_LOAD;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (list.valid) begin
            cur_len  <= list.length;
            cur_base <= list.base_dest;
        end
        if (state == ST_READ_RIGHT) begin
            left <= rd_data;
        end
    end

    // the loader must stay quiet while the unloader owns the store
    a_write_phase: assert property (@(posedge clock) disable iff (reset)
        mem_wr.en |-> (phase == PHASE_LOAD || phase == PHASE_SORT));

    a_length: assert property (@(posedge clock) disable iff (reset)
        list.valid |-> list.length != '0);

endmodule

/* sort_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// argument loader
// writes incoming beats into the list store, counts them and
// reports the finished list once the last beat arrives
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sort_loader import sorter_pkg::*; #(
    parameter int MAX_SORT_LENGTH = 256
) (
    input  logic         clock,
    input  logic         reset,
    input  stream_beat_t arg,
    input  logic         arg_valid,
    output logic         arg_ready,
    input  logic         load_enable,
    output mem_write_t   wr,
    output list_info_t   list
);

    localparam logic [ADDR_WIDTH:0] MAX_LEN = (ADDR_WIDTH+1)'(MAX_SORT_LENGTH);

    logic [ADDR_WIDTH:0]   count;
    logic [DEST_WIDTH-1:0] base_dest;
    logic                  accept;
    logic                  room;
    logic                  list_valid;
    logic [ADDR_WIDTH:0]   list_length;
    logic [DEST_WIDTH-1:0] list_base;

    assign arg_ready = load_enable;
    assign accept    = arg_valid && arg_ready;
    assign room      = count < MAX_LEN;

    // beats beyond the limit are taken from the stream but never stored
    assign wr = '{en: accept && room, addr: count[ADDR_WIDTH-1:0], data: arg.data};

    assign list = '{valid: list_valid, length: list_length, base_dest: list_base};

    always_ff @(posedge clock) begin
        if (reset) begin
            count      <= '0;
            list_valid <= 1'b0;
        end else begin
            list_valid <= accept && arg.last;
            if (accept) begin
                if (arg.last) begin
                    count <= '0;
                end else if (room) begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept && count == '0) begin
            base_dest <= arg.dest;
        end
        if (accept && arg.last) begin
            list_length <= room ? count + 1'b1 : count;
            // a single beat list has not latched its base yet
            list_base   <= (count == '0) ? arg.dest : base_dest;
        end
    end

    // the engine has to close the argument port as soon as a list is reported
    a_single_report: assert property (@(posedge clock) disable iff (reset)
        list.valid |=> !list.valid);

endmodule

/* sort_memory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// list store
// one write port and one synchronous read port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sort_memory import sorter_pkg::*; #(
    parameter int MAX_SORT_LENGTH = 256
) (
    input  logic       clock,
    input  mem_write_t wr,
    input  mem_read_t  rd,
    output sort_data_t rd_data
);

    // only the low address bits select an entry, the length limit keeps
    // every access inside the array
    localparam int IDX_WIDTH = $clog2(MAX_SORT_LENGTH);

    sort_data_t mem [MAX_SORT_LENGTH];

    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr.addr[IDX_WIDTH-1:0]] <= wr.data;
        end
        // read data holds between requests, the engine relies on that
        if (rd.en) begin
            rd_data <= mem[rd.addr[IDX_WIDTH-1:0]];
        end
    end

endmodule

/* sorter_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sorter package
// widths, stream beat, memory request bundles and the phase
// encoding shared by every block of the sorter unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sorter_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int DEST_WIDTH = 8;
    // index range of the list store, lists of up to 256 words
    localparam int ADDR_WIDTH = 8;

    typedef logic signed [DATA_WIDTH-1:0] sort_data_t;

    typedef struct packed {
        sort_data_t            data;
        logic [DEST_WIDTH-1:0] dest;
        logic                  last;
    } stream_beat_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        sort_data_t            data;
    } mem_write_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } mem_read_t;

    // length needs one extra bit so that a full store can be described
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH:0]   length;
        logic [DEST_WIDTH-1:0] base_dest;
    } list_info_t;

    typedef enum logic [1:0] {
        PHASE_LOAD,
        PHASE_SORT,
        PHASE_UNLOAD
    } sorter_phase_t;

endpackage
